//--- hdl/swarm_macros.svh
`ifndef SWARM_MACROS_SVH
`define SWARM_MACROS_SVH

// Field widths
`define SLOT_BITS     6
`define THREAD_BITS   4
`define CHILD_BITS    4
`define UNDO_ID_BITS  4

// Core ID selects one bit of the start register
`define CORE_ID       0

// Engine reset length on abort, in cycles
`define ABORT_HOLD    4

// Register map
`define REG_CORE_START  8'h00
`define REG_N_DEQUEUES  8'h04
`define REG_NUM_ENQ     8'h08
`define REG_NUM_DEQ     8'h0c
`define REG_STATE       8'h10

`endif

//--- hdl/swarm_pkg.sv
`include "swarm_macros.svh"

package swarm_pkg;

   typedef logic [`SLOT_BITS-1:0]    cq_slot_t;
   typedef logic [`THREAD_BITS-1:0]  thread_id_t;
   typedef logic [`CHILD_BITS-1:0]   child_id_t;
   typedef logic [`UNDO_ID_BITS-1:0] undo_id_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [15:0] locale;
      logic [3:0]  ttype;
      logic [31:0] args;
   } task_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } undo_rec_t;

   typedef struct packed {
      logic        valid;
      logic [7:0]  addr;
      logic [31:0] data;
   } reg_wr_t;

   typedef struct packed {
      logic        valid;
      logic [7:0]  addr;
   } reg_rd_req_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
   } reg_rd_rsp_t;

   typedef enum logic [2:0] {
      NEXT_TASK,
      INFORM_CQ,
      START_CORE,
      WAIT_CORE,
      ABORT_TASK,
      FINISH_TASK
   } seq_state_t;

endpackage

//--- hdl/core_regs.sv
`timescale 1ns/1ps
`include "swarm_macros.svh"

module core_regs import swarm_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  reg_wr_t     reg_wr,
   input  reg_rd_req_t reg_rd_req,
   output reg_rd_rsp_t reg_rd_rsp,
   input  logic        dequeued,
   input  logic        enqueued,
   input  seq_state_t  state,
   output logic        run_enable
);

   logic        start;
   logic [31:0] dequeues_left;
   logic [31:0] num_enq;
   logic [31:0] num_deq;
   logic        rsp_valid;
   logic [31:0] rsp_data;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start <= 1'b0;
      end else if (reg_wr.valid && reg_wr.addr == `REG_CORE_START) begin
         start <= reg_wr.data[`CORE_ID];
      end
   end

   // A budget write wins over a dequeue in the same cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         dequeues_left <= '1;
      end else if (reg_wr.valid && reg_wr.addr == `REG_N_DEQUEUES) begin
         dequeues_left <= reg_wr.data;
      end else if (dequeued) begin
         dequeues_left <= dequeues_left - 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         num_enq <= '0;
         num_deq <= '0;
      end else begin
         if (enqueued) begin
            num_enq <= num_enq + 32'd1;
         end
         if (dequeued) begin
            num_deq <= num_deq + 32'd1;
         end
      end
   end

   assign run_enable = start && (dequeues_left != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= reg_rd_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd_req.valid) begin
         case (reg_rd_req.addr)
            `REG_N_DEQUEUES: rsp_data <= dequeues_left;
            `REG_NUM_ENQ:    rsp_data <= num_enq;
            `REG_NUM_DEQ:    rsp_data <= num_deq;
            `REG_STATE:      rsp_data <= 32'(state);
            default:         rsp_data <= '0;
         endcase
      end
   end

   assign reg_rd_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

//--- hdl/task_sequencer.sv
`timescale 1ns/1ps
`include "swarm_macros.svh"

module task_sequencer import swarm_pkg::*; (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      run_enable,
   // Dequeue
   output logic                      task_arvalid,
   input  logic                      task_rvalid,
   input  task_t                     task_rdata,
   input  cq_slot_t                  task_rslot,
   input  thread_id_t                task_rthread,
   // Start inform
   output logic                      start_task_valid,
   input  logic                      start_task_ready,
   output cq_slot_t                  start_task_slot,
   // Finish
   output logic                      finish_task_valid,
   input  logic                      finish_task_ready,
   output cq_slot_t                  finish_task_slot,
   output thread_id_t                finish_task_thread,
   output child_id_t                 finish_task_num_children,
   output logic                      finish_task_undo_log_write,
   // Abort and commit status
   input  logic [2**`SLOT_BITS-1:0]  task_aborted,
   input  logic                      gvt_slot_valid,
   input  cq_slot_t                  gvt_slot,
   // Engine control
   output logic                      eng_start,
   output task_t                     eng_task,
   output logic                      eng_rstn,
   input  logic                      eng_done,
   // Output buffers
   input  logic                      child_hs,
   input  logic                      bufs_busy,
   output logic                      drop,
   output cq_slot_t                  cur_slot,
   output logic                      untied,
   output child_id_t                 child_id,
   input  logic                      undo_written,
   output seq_state_t                state
);

   seq_state_t state_next;
   thread_id_t cur_thread;
   logic       dequeue;
   logic       finish_hs;
   logic       abort_now;
   logic       aborted_q;
   logic       abort_mark;
   logic [3:0] hold_cnt;

   assign dequeue   = task_arvalid && task_rvalid;
   assign finish_hs = finish_task_valid && finish_task_ready;

   // Abort of the running slot only counts before the engine is done
   assign abort_now  = task_aborted[cur_slot] &&
                       (state == INFORM_CQ || state == WAIT_CORE);
   assign abort_mark = aborted_q || abort_now;

   always_comb begin
      state_next = state;
      case (state)
         NEXT_TASK: begin
            if (dequeue) begin
               state_next = INFORM_CQ;
            end
         end
         INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = abort_mark ? FINISH_TASK : START_CORE;
            end
         end
         START_CORE: state_next = WAIT_CORE;
         WAIT_CORE: begin
            if (eng_done) begin
               state_next = FINISH_TASK;
            end else if (abort_mark) begin
               state_next = ABORT_TASK;
            end
         end
         ABORT_TASK: begin
            if (hold_cnt == '0) begin
               state_next = FINISH_TASK;
            end
         end
         FINISH_TASK: begin
            if (finish_hs) begin
               state_next = NEXT_TASK;
            end
         end
         default: state_next = NEXT_TASK;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= NEXT_TASK;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (dequeue) begin
         cur_slot   <= task_rslot;
         cur_thread <= task_rthread;
         eng_task   <= task_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         aborted_q <= 1'b0;
      end else if (dequeue) begin
         aborted_q <= 1'b0;
      end else if (abort_now) begin
         aborted_q <= 1'b1;
      end
   end

   // Engine also sits in reset for a few cycles after system reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_cnt <= 4'(`ABORT_HOLD);
      end else if (state == WAIT_CORE && state_next == ABORT_TASK) begin
         hold_cnt <= 4'(`ABORT_HOLD);
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 4'd1;
      end
   end

   // Only tied children get counted for the CQ
   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_id <= '0;
      end else if (dequeue) begin
         child_id <= '0;
      end else if (child_hs && !untied) begin
         child_id <= child_id + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         untied <= 1'b0;
      end else begin
         untied <= gvt_slot_valid && (gvt_slot == cur_slot);
      end
   end

   assign eng_rstn     = (hold_cnt == '0);
   assign eng_start    = (state == START_CORE);
   assign drop         = (state == ABORT_TASK);
   assign task_arvalid = (state == NEXT_TASK) && run_enable && eng_rstn;

   assign start_task_valid = (state == INFORM_CQ);
   assign start_task_slot  = cur_slot;

   assign finish_task_valid          = (state == FINISH_TASK) && !bufs_busy;
   assign finish_task_slot           = cur_slot;
   assign finish_task_thread         = cur_thread;
   assign finish_task_num_children   = child_id;
   assign finish_task_undo_log_write = undo_written;

endmodule

//--- hdl/app_engine.sv
`timescale 1ns/1ps

module app_engine import swarm_pkg::*; (
   input  logic      clk,
   input  logic      eng_rstn,
   input  logic      eng_start,
   input  task_t     eng_task,
   output logic      child_valid,
   output task_t     child_task,
   input  logic      child_ready,
   output logic      undo_valid,
   output undo_rec_t undo_rec,
   input  logic      undo_ready,
   output logic      eng_done
);

   typedef enum logic [1:0] {
      ENG_IDLE,
      ENG_CHILD,
      ENG_UNDO,
      ENG_DONE
   } eng_state_t;

   eng_state_t  eng_state;
   task_t       parent;
   logic [1:0]  child_cnt;
   logic [1:0]  num_children;
   logic [31:0] offset;

   assign num_children = parent.args[1:0];
   assign offset       = 32'(child_cnt) + 32'd1;

   always_ff @(posedge clk) begin
      if (!eng_rstn) begin
         eng_state <= ENG_IDLE;
         child_cnt <= '0;
      end else begin
         case (eng_state)
            ENG_IDLE: begin
               if (eng_start) begin
                  child_cnt <= '0;
                  eng_state <= (eng_task.args[1:0] == 2'd0) ? ENG_UNDO : ENG_CHILD;
               end
            end
            ENG_CHILD: begin
               if (child_ready) begin
                  child_cnt <= child_cnt + 2'd1;
                  if (child_cnt == num_children - 2'd1) begin
                     eng_state <= ENG_UNDO;
                  end
               end
            end
            ENG_UNDO: begin
               if (undo_ready) begin
                  eng_state <= ENG_DONE;
               end
            end
            default: eng_state <= ENG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (eng_state == ENG_IDLE && eng_start) begin
         parent <= eng_task;
      end
   end

   // Child i is offset by i+1 in both ts and locale
   assign child_task = '{ts:     parent.ts + offset,
                         locale: parent.locale + offset[15:0],
                         ttype:  '0,
                         args:   '0};

   assign undo_rec = '{addr: 32'(parent.locale), data: parent.ts};

   assign child_valid = (eng_state == ENG_CHILD);
   assign undo_valid  = (eng_state == ENG_UNDO);
   assign eng_done    = (eng_state == ENG_DONE);

endmodule

//--- hdl/core_out_buffers.sv
`timescale 1ns/1ps

module core_out_buffers import swarm_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  logic      drop,
   input  cq_slot_t  cur_slot,
   // From the engine
   input  logic      child_valid,
   input  task_t     child_task,
   output logic      child_ready,
   input  logic      undo_valid,
   input  undo_rec_t undo_rec,
   output logic      undo_ready,
   // Enqueue port
   output logic      task_wvalid,
   output task_t     task_wdata,
   input  logic      task_wready,
   // Undo-log port
   output logic      undo_log_valid,
   output undo_rec_t undo_log_rec,
   output undo_id_t  undo_log_id,
   output cq_slot_t  undo_log_slot,
   input  logic      undo_log_ready,
   input  logic      finish_hs,
   output logic      busy,
   output logic      undo_written
);

   logic child_acc;
   logic undo_acc;

   // Nothing new is taken while an abort is being handled
   assign child_ready = !task_wvalid && !drop;
   assign undo_ready  = !undo_log_valid && !drop;
   assign child_acc   = child_valid && child_ready;
   assign undo_acc    = undo_valid && undo_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (drop) begin
         task_wvalid <= 1'b0;
      end else if (child_acc) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (child_acc) begin
         task_wdata <= child_task;
      end
   end

   // A pending undo record survives an abort
   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_valid <= 1'b0;
      end else if (undo_acc) begin
         undo_log_valid <= 1'b1;
      end else if (undo_log_ready) begin
         undo_log_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (undo_acc) begin
         undo_log_rec  <= undo_rec;
         undo_log_slot <= cur_slot;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_id  <= '0;
         undo_written <= 1'b0;
      end else if (finish_hs) begin
         undo_log_id  <= '0;
         undo_written <= 1'b0;
      end else begin
         if (undo_log_valid && undo_log_ready) begin
            undo_log_id <= undo_log_id + 1'b1;
         end
         if (undo_acc) begin
            undo_written <= 1'b1;
         end
      end
   end

   assign busy = task_wvalid || undo_log_valid;

endmodule

//--- hdl/core_top.sv
`timescale 1ns/1ps
`include "swarm_macros.svh"

module core_top import swarm_pkg::*; (
   input  logic                      clk,
   input  logic                      rstn,
   // Task dequeue
   output logic                      task_arvalid,
   input  logic                      task_rvalid,
   input  task_t                     task_rdata,
   input  cq_slot_t                  task_rslot,
   input  thread_id_t                task_rthread,
   // Task enqueue
   output logic                      task_wvalid,
   output task_t                     task_wdata,
   input  logic                      task_wready,
   output logic                      task_enq_untied,
   output cq_slot_t                  task_cq_slot,
   output child_id_t                 task_child_id,
   // Start inform
   output logic                      start_task_valid,
   input  logic                      start_task_ready,
   output cq_slot_t                  start_task_slot,
   // Finish
   output logic                      finish_task_valid,
   input  logic                      finish_task_ready,
   output cq_slot_t                  finish_task_slot,
   output thread_id_t                finish_task_thread,
   output child_id_t                 finish_task_num_children,
   output logic                      finish_task_undo_log_write,
   // Abort and GVT
   input  logic [2**`SLOT_BITS-1:0]  task_aborted,
   input  logic                      gvt_slot_valid,
   input  cq_slot_t                  gvt_slot,
   // Undo log
   output logic                      undo_log_valid,
   input  logic                      undo_log_ready,
   output undo_id_t                  undo_log_id,
   output undo_rec_t                 undo_log_rec,
   output cq_slot_t                  undo_log_slot,
   // Register bus
   input  reg_wr_t                   reg_wr,
   input  reg_rd_req_t               reg_rd_req,
   output reg_rd_rsp_t               reg_rd_rsp
);

   wire dequeued  = task_arvalid & task_rvalid;
   wire child_hs  = task_wvalid & task_wready;
   wire finish_hs = finish_task_valid & finish_task_ready;

   seq_state_t state;
   logic       run_enable;
   logic       eng_start;
   task_t      eng_task;
   logic       eng_rstn;
   logic       eng_done;
   logic       drop;
   logic       bufs_busy;
   logic       undo_written;
   logic       child_valid;
   task_t      child_task;
   logic       child_ready;
   logic       undo_valid;
   undo_rec_t  undo_rec;
   logic       undo_ready;

   core_regs regs0 (
      .clk        (clk),
      .rstn       (rstn),
      .reg_wr     (reg_wr),
      .reg_rd_req (reg_rd_req),
      .reg_rd_rsp (reg_rd_rsp),
      .dequeued   (dequeued),
      .enqueued   (child_hs),
      .state      (state),
      .run_enable (run_enable)
   );

   task_sequencer seq0 (
      .clk                        (clk),
      .rstn                       (rstn),
      .run_enable                 (run_enable),
      .task_arvalid               (task_arvalid),
      .task_rvalid                (task_rvalid),
      .task_rdata                 (task_rdata),
      .task_rslot                 (task_rslot),
      .task_rthread               (task_rthread),
      .start_task_valid           (start_task_valid),
      .start_task_ready           (start_task_ready),
      .start_task_slot            (start_task_slot),
      .finish_task_valid          (finish_task_valid),
      .finish_task_ready          (finish_task_ready),
      .finish_task_slot           (finish_task_slot),
      .finish_task_thread         (finish_task_thread),
      .finish_task_num_children   (finish_task_num_children),
      .finish_task_undo_log_write (finish_task_undo_log_write),
      .task_aborted               (task_aborted),
      .gvt_slot_valid             (gvt_slot_valid),
      .gvt_slot                   (gvt_slot),
      .eng_start                  (eng_start),
      .eng_task                   (eng_task),
      .eng_rstn                   (eng_rstn),
      .eng_done                   (eng_done),
      .child_hs                   (child_hs),
      .bufs_busy                  (bufs_busy),
      .drop                       (drop),
      .cur_slot                   (task_cq_slot),
      .untied                     (task_enq_untied),
      .child_id                   (task_child_id),
      .undo_written               (undo_written),
      .state                      (state)
   );

   app_engine eng0 (
      .clk         (clk),
      .eng_rstn    (eng_rstn),
      .eng_start   (eng_start),
      .eng_task    (eng_task),
      .child_valid (child_valid),
      .child_task  (child_task),
      .child_ready (child_ready),
      .undo_valid  (undo_valid),
      .undo_rec    (undo_rec),
      .undo_ready  (undo_ready),
      .eng_done    (eng_done)
   );

   core_out_buffers bufs0 (
      .clk            (clk),
      .rstn           (rstn),
      .drop           (drop),
      .cur_slot       (task_cq_slot),
      .child_valid    (child_valid),
      .child_task     (child_task),
      .child_ready    (child_ready),
      .undo_valid     (undo_valid),
      .undo_rec       (undo_rec),
      .undo_ready     (undo_ready),
      .task_wvalid    (task_wvalid),
      .task_wdata     (task_wdata),
      .task_wready    (task_wready),
      .undo_log_valid (undo_log_valid),
      .undo_log_rec   (undo_log_rec),
      .undo_log_id    (undo_log_id),
      .undo_log_slot  (undo_log_slot),
      .undo_log_ready (undo_log_ready),
      .finish_hs      (finish_hs),
      .busy           (bufs_busy),
      .undo_written   (undo_written)
   );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
   end

endmodule

//--- bench/core_asserts.sv
`timescale 1ns/1ps

module core_asserts import swarm_pkg::*; (
   input logic      clk,
   input logic      rstn,
   input logic      task_arvalid,
   input logic      task_rvalid,
   input logic      task_wvalid,
   input logic      task_wready,
   input task_t     task_wdata,
   input logic      drop,
   input logic      undo_log_valid,
   input logic      undo_log_ready,
   input undo_rec_t undo_log_rec,
   input logic      start_task_valid,
   input logic      start_task_ready,
   input logic      finish_task_valid,
   input logic      finish_task_ready
);

   int fail_cnt = 0;
   logic in_flight;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         in_flight <= 1'b0;
      end else if (task_arvalid && task_rvalid) begin
         in_flight <= 1'b1;
      end else if (finish_task_valid && finish_task_ready) begin
         in_flight <= 1'b0;
      end
   end

   // A pending child holds until accepted, unless an abort drops it
   enq_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready && !drop |=> task_wvalid && $stable(task_wdata))
      else begin $error("child enqueue released without handshake"); fail_cnt++; end

   undo_hold: assert property (@(posedge clk) disable iff (!rstn)
      undo_log_valid && !undo_log_ready |=> undo_log_valid && $stable(undo_log_rec))
      else begin $error("undo record released without handshake"); fail_cnt++; end

   start_hold: assert property (@(posedge clk) disable iff (!rstn)
      start_task_valid && !start_task_ready |=> start_task_valid)
      else begin $error("start inform released without handshake"); fail_cnt++; end

   finish_hold: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid && !finish_task_ready |=> finish_task_valid)
      else begin $error("finish released without handshake"); fail_cnt++; end

   // The finished task leaves nothing behind on the output ports
   finish_clean: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid && finish_task_ready |=> !task_wvalid && !undo_log_valid)
      else begin $error("output raised right after a finish"); fail_cnt++; end

   // A new dequeue waits for the finish of the running task
   one_in_flight: assert property (@(posedge clk) disable iff (!rstn)
      task_arvalid |-> !in_flight)
      else begin $error("dequeue requested while a task is in flight"); fail_cnt++; end

endmodule

bind core_top core_asserts asserts0 (.*);

//--- bench/core_tb.sv
`timescale 1ns/1ps
`include "swarm_macros.svh"

module core_tb import swarm_pkg::*; ();

   localparam int NUM_TASKS = 12;
   localparam int MAX_CYCLES = 4000;

   logic clk;
   logic rstn;

   logic                     task_arvalid, task_rvalid, task_wvalid, task_wready;
   task_t                    task_rdata, task_wdata;
   cq_slot_t                 task_rslot, task_cq_slot, start_task_slot, finish_task_slot;
   thread_id_t               task_rthread, finish_task_thread;
   logic                     task_enq_untied;
   child_id_t                task_child_id, finish_task_num_children;
   logic                     start_task_valid, start_task_ready;
   logic                     finish_task_valid, finish_task_ready, finish_task_undo_log_write;
   logic [2**`SLOT_BITS-1:0] task_aborted;
   logic                     gvt_slot_valid;
   cq_slot_t                 gvt_slot;
   logic                     undo_log_valid, undo_log_ready;
   undo_id_t                 undo_log_id;
   undo_rec_t                undo_log_rec;
   cq_slot_t                 undo_log_slot;
   reg_wr_t                  reg_wr;
   reg_rd_req_t              reg_rd_req;
   reg_rd_rsp_t              reg_rd_rsp;

   logic [31:0] lfsr = 32'h8b43bc40;
   int errors = 0;
   int cycles = 0;
   bit started = 0;
   int q_idx = 0;
   int run_idx = 0;
   int deq_total = 0;
   int enq_total = 0;
   int fin_total = 0;
   int enq_n[NUM_TASKS];
   int tied_n[NUM_TASKS];
   int undo_n[NUM_TASKS];
   int fin_n[NUM_TASKS];
   bit finished[NUM_TASKS];
   int abort_wait = -1;

   tb_clock clk0 (.clk(clk), .rstn(rstn));

   core_top dut0 (.*);

   function automatic logic [31:0] ts_of(int i);
      return 32'(100 * i);
   endfunction

   function automatic logic [15:0] locale_of(int i);
      return 16'(16'h0200 + 16 * i);
   endfunction

   function automatic thread_id_t thread_of(int i);
      return thread_id_t'((i + 3) % 16);
   endfunction

   function automatic task_t make_task(int i);
      return '{ts: ts_of(i), locale: locale_of(i), ttype: 4'd1, args: 32'(i)};
   endfunction

   function automatic bit is_aborted(int i);
      return (i == 3) || (i == 8);
   endfunction

   // Taps 32, 22, 2, 1; one step per bit taken
   function logic next_bit();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   task automatic check_val(string name, longint got, longint exp);
      assert (got == exp)
      else begin
         $display("ERROR %0t %s: got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(bit cond, string what);
      assert (cond)
      else begin
         $display("At %0t: %s", $time, what);
         errors++;
      end
   endtask

   task automatic reg_write(logic [7:0] addr, logic [31:0] data);
      @(posedge clk);
      reg_wr <= '{valid: 1'b1, addr: addr, data: data};
      @(posedge clk);
      reg_wr <= '0;
   endtask

   task automatic reg_read_check(logic [7:0] addr, logic [31:0] exp, string name);
      @(posedge clk);
      reg_rd_req <= '{valid: 1'b1, addr: addr};
      @(posedge clk);
      reg_rd_req <= '0;
      check_val("reg_rd_rsp.valid", reg_rd_rsp.valid, 0);
      @(posedge clk);
      check_val("reg_rd_rsp.valid", reg_rd_rsp.valid, 1);
      check_val(name, reg_rd_rsp.data, exp);
   endtask

   initial begin
      task_rvalid       = 1'b1;
      task_rdata        = make_task(0);
      task_rslot        = '0;
      task_rthread      = thread_of(0);
      task_wready       = 1'b0;
      start_task_ready  = 1'b0;
      finish_task_ready = 1'b0;
      undo_log_ready    = 1'b0;
      task_aborted      = '0;
      gvt_slot_valid    = 1'b1;
      gvt_slot          = 6'd5;
      reg_wr            = '0;
      reg_rd_req        = '0;
      foreach (enq_n[i]) begin
         enq_n[i]    = 0;
         tied_n[i]   = 0;
         undo_n[i]   = 0;
         fin_n[i]    = 0;
         finished[i] = 0;
      end
   end

   // Queue and commit-queue models, plus the per-cycle checks
   always @(posedge clk) begin
      int idx;
      if (rstn) begin
         if (!started) begin
            check_val("task_arvalid", task_arvalid, 0);
            check_val("start_task_valid", start_task_valid, 0);
            check_val("task_wvalid", task_wvalid, 0);
            check_val("undo_log_valid", undo_log_valid, 0);
            check_val("finish_task_valid", finish_task_valid, 0);
            check_val("reg_rd_rsp.valid", reg_rd_rsp.valid, 0);
         end
         if (deq_total == NUM_TASKS) begin
            check_val("task_arvalid", task_arvalid, 0);
         end
         if (task_arvalid && task_rvalid) begin
            run_idx = q_idx;
            q_idx++;
            deq_total++;
            task_rvalid  <= (q_idx < NUM_TASKS);
            task_rdata   <= make_task(q_idx);
            task_rslot   <= cq_slot_t'(q_idx);
            task_rthread <= thread_of(q_idx);
         end
         if (start_task_valid && start_task_ready) begin
            check_val("start_task_slot", start_task_slot, run_idx);
            if (is_aborted(run_idx)) begin
               abort_wait = {next_bit(), next_bit()};
            end
         end
         if (abort_wait == 0) begin
            task_aborted[run_idx] <= 1'b1;
         end
         if (abort_wait >= 0) begin
            abort_wait--;
         end
         if (task_wvalid && task_wready) begin
            idx = run_idx;
            check_val("task_cq_slot", task_cq_slot, run_idx);
            check_true(!finished[idx], "child enqueued after its parent finished");
            check_val("task_enq_untied", task_enq_untied,
                      gvt_slot_valid && (int'(gvt_slot) == idx));
            check_val("task_child_id", task_child_id, tied_n[idx]);
            if (!is_aborted(idx)) begin
               check_val("task_wdata.ts", task_wdata.ts, ts_of(idx) + enq_n[idx] + 1);
               check_val("task_wdata.locale", task_wdata.locale,
                         16'(locale_of(idx) + enq_n[idx] + 1));
               check_val("task_wdata.ttype", task_wdata.ttype, 0);
               check_val("task_wdata.args", task_wdata.args, 0);
            end
            enq_n[idx]++;
            enq_total++;
            if (!task_enq_untied) begin
               tied_n[idx]++;
            end
         end
         if (undo_log_valid && undo_log_ready) begin
            idx = run_idx;
            check_val("undo_log_slot", undo_log_slot, run_idx);
            if (!is_aborted(idx)) begin
               check_val("undo_log_rec.addr", undo_log_rec.addr, 32'(locale_of(idx)));
               check_val("undo_log_rec.data", undo_log_rec.data, ts_of(idx));
               check_val("undo_log_id", undo_log_id, 0);
            end
            undo_n[idx]++;
         end
         if (finish_task_valid && finish_task_ready) begin
            check_val("finish_task_slot", finish_task_slot, run_idx);
            check_val("finish_task_thread", finish_task_thread, thread_of(run_idx));
            check_val("task_wvalid", task_wvalid, 0);
            check_val("undo_log_valid", undo_log_valid, 0);
            if (!is_aborted(run_idx)) begin
               check_val("finish_task_num_children", finish_task_num_children,
                         tied_n[run_idx]);
               check_val("finish_task_undo_log_write", finish_task_undo_log_write, 1);
               check_val("undo writes", undo_n[run_idx], 1);
            end
            fin_n[run_idx]++;
            finished[run_idx] = 1;
            fin_total++;
            abort_wait = -1;
            task_aborted <= '0;
         end
      end
      task_wready       <= next_bit();
      start_task_ready  <= next_bit();
      finish_task_ready <= next_bit();
      undo_log_ready    <= next_bit();
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      int total_errors;
      @(posedge rstn);
      repeat (5) @(posedge clk);
      reg_write(`REG_N_DEQUEUES, 32'd12);
      started <= 1'b1;
      reg_write(`REG_CORE_START, 32'd1 << `CORE_ID);
      wait (fin_total == NUM_TASKS);
      repeat (4) @(posedge clk);
      check_val("dequeues", deq_total, NUM_TASKS);
      for (int i = 0; i < NUM_TASKS; i++) begin
         check_val("finishes per slot", fin_n[i], 1);
         if (!is_aborted(i)) begin
            // Child count is the low two bits of args
            check_val("enqueues per task", enq_n[i], i % 4);
            check_val("undo writes per task", undo_n[i], 1);
         end
      end
      reg_read_check(`REG_NUM_DEQ, 32'd12, "REG_NUM_DEQ");
      reg_read_check(`REG_N_DEQUEUES, 32'd0, "REG_N_DEQUEUES");
      reg_read_check(`REG_NUM_ENQ, 32'(enq_total), "REG_NUM_ENQ");
      reg_read_check(`REG_STATE, 32'(NEXT_TASK), "REG_STATE");
      reg_read_check(8'hfc, 32'd0, "unknown register");
      repeat (2) @(posedge clk);
      total_errors = errors + dut0.asserts0.fail_cnt;
      $display("Checks failed: %0d, assertions failed: %0d, enqueues: %0d",
               errors, dut0.asserts0.fail_cnt, enq_total);
      if (total_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
+incdir+hdl
hdl/swarm_pkg.sv
hdl/core_regs.sv
hdl/task_sequencer.sv
hdl/app_engine.sv
hdl/core_out_buffers.sv
hdl/core_top.sv
bench/tb_clock.sv
bench/core_asserts.sv
bench/core_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module core_tb -Mdir obj_dir -f build.f

run: compile
	@out="$$(./obj_dir/Vcore_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
